/* include/tx_ack_defines.svh */
// tx ack controller constants
`ifndef TX_ACK_DEFINES_SVH
`define TX_ACK_DEFINES_SVH

// core clock in cycles per microsecond
`define CLK_PER_US 100

// frame control type field
`define FC_TYPE_MGMT 2'b00
`define FC_TYPE_CTRL 2'b01
`define FC_TYPE_DATA 2'b10

// frame control subtype field
`define FC_SUB_BAR          4'b1000
`define FC_SUB_BA           4'b1001
`define FC_SUB_PSPOLL       4'b1010
`define FC_SUB_ACK          4'b1101
// management action frame that asks for no ack
`define FC_SUB_ACTION_NOACK 4'b1110

// ack ppdu, legacy 6 Mb/s, 14 byte mpdu
`define ACK_RATE_CODE   4'b1011
`define ACK_LEN         12'd14
// preamble plus signal 20 us, six data symbols of 4 us
`define ACK_AIR_TIME_US 16'd44

// field widths
`define MAC_ADDR_W 48
`define RETRY_W    4
`define TIMER_W    24

`endif

/* rtl/tx_ack_pkg.sv */
// tx ack controller types
`include "tx_ack_defines.svh"

package tx_ack_pkg;

  // kind of the last received frame
  // only acked kinds are listed, everything else is none
  typedef enum logic [2:0] {
    KIND_NONE   = 3'd0,
    KIND_DATA   = 3'd1,
    KIND_MGMT   = 3'd2,
    KIND_BAR    = 3'd3,
    KIND_BA     = 3'd4,
    KIND_PSPOLL = 3'd5
  } frame_kind_t;

  // controller states
  // ack_wait   sifs wait before our own ack goes out
  // ack_send   ack on air until phy done
  // wait_ack   our frame sent, listening for the peer ack
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    ACK_WAIT = 2'd1,
    ACK_SEND = 2'd2,
    WAIT_ACK = 2'd3
  } ctrl_state_t;

  // locked result of one transmit attempt
  // fail set when retries ran out without an ack
  typedef struct packed {
    logic                fail;
    logic [`RETRY_W-1:0] retry;
  } tx_status_t;

endpackage

/* rtl/frame_classify.sv */
// received frame classifier
`timescale 1ns/100ps
`include "tx_ack_defines.svh"

module frame_classify import tx_ack_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  // end of frame strobe and the parsed header fields
  input  logic                   rx_valid,
  input  logic                   fcs_ok,
  input  logic [1:0]             fc_type,
  input  logic [3:0]             fc_subtype,
  input  logic                   more_frag,
  input  logic [15:0]            duration,
  input  logic [`MAC_ADDR_W-1:0] addr1,
  input  logic [`MAC_ADDR_W-1:0] addr2,
  input  logic [`MAC_ADDR_W-1:0] self_mac_addr,
  // events to the controller
  output logic                   ack_owed,
  output logic                   ack_seen,
  // fields kept for the ack builder
  output frame_kind_t            kind,
  output logic                   rx_more_frag,
  output logic [15:0]            rx_duration,
  output logic [`MAC_ADDR_W-1:0] rx_addr2
);

  frame_kind_t kind_d;
  logic        for_us;
  logic        is_ack;
  logic        owe_d;
  logic        seen_d;

  // kind decode from type and subtype
  always_comb begin
    kind_d = KIND_NONE;
    case (fc_type)
      `FC_TYPE_DATA: kind_d = KIND_DATA;
      `FC_TYPE_MGMT: begin
        // action no ack must stay unanswered
        if (fc_subtype != `FC_SUB_ACTION_NOACK) begin
          kind_d = KIND_MGMT;
        end
      end
      `FC_TYPE_CTRL: begin
        case (fc_subtype)
          `FC_SUB_BAR:    kind_d = KIND_BAR;
          `FC_SUB_BA:     kind_d = KIND_BA;
          `FC_SUB_PSPOLL: kind_d = KIND_PSPOLL;
          default:        kind_d = KIND_NONE;
        endcase
      end
      default: kind_d = KIND_NONE;
    endcase
  end

  // individually addressed to this station
  assign for_us = (addr1 == self_mac_addr);
  // control frame with ack subtype
  assign is_ack = (fc_type == `FC_TYPE_CTRL) && (fc_subtype == `FC_SUB_ACK);

  assign owe_d  = rx_valid && fcs_ok && for_us && (kind_d != KIND_NONE);
  assign seen_d = rx_valid && fcs_ok && for_us && is_ack;

  // event strobes and kind, one cycle after rx_valid
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ack_owed <= 1'b0;
      ack_seen <= 1'b0;
      kind     <= KIND_NONE;
    end else begin
      ack_owed <= owe_d;
      ack_seen <= seen_d;
      if (owe_d) begin
        kind <= kind_d;
      end
    end
  end

  // header fields, only taken when an ack is owed
  always_ff @(posedge clk) begin
    if (owe_d) begin
      rx_more_frag <= more_frag;
      rx_duration  <= duration;
      rx_addr2     <= addr2;
    end
  end

  // an ack frame is never itself acked
  a_owed_seen_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(ack_owed && ack_seen));

endmodule

/* rtl/tx_ack_fsm.sv */
// ack send and retry controller
`timescale 1ns/100ps
`include "tx_ack_defines.svh"

module tx_ack_fsm import tx_ack_pkg::*; (
  input  logic                clk,
  input  logic                rstn,
  // events from the classifier
  input  logic                ack_owed,
  input  logic                ack_seen,
  // phy and upper layer
  input  logic                phy_tx_done,
  input  logic                tx_need_ack,
  // configuration
  input  logic [7:0]          send_ack_wait_us,
  input  logic [11:0]         ack_timeout_us,
  input  logic [`RETRY_W-1:0] retrans_limit,
  // ack transmit control
  output logic                start_tx_ack,
  output logic                ack_launch,
  output logic                ack_busy,
  // retransmission and result
  output logic                start_retrans,
  output logic                retrans_in_progress,
  output logic                tx_try_complete,
  output tx_status_t          tx_status
);

  // cycles per microsecond at timer width
  localparam logic [`TIMER_W-1:0] CYC_PER_US = `TIMER_W'(`CLK_PER_US);

  ctrl_state_t         state;
  logic [`TIMER_W-1:0] timer;
  logic [`RETRY_W-1:0] num_retrans;
  logic [`TIMER_W-1:0] wait_cycles;
  logic [`TIMER_W-1:0] timeout_cycles;
  logic                retry_left;

  // microsecond settings scaled to clock cycles
  assign wait_cycles    = `TIMER_W'(send_ack_wait_us) * CYC_PER_US;
  assign timeout_cycles = `TIMER_W'(ack_timeout_us) * CYC_PER_US;

  // limit of 0 means no retransmission at all
  assign retry_left = (num_retrans < retrans_limit);

  // busy over the sifs wait and the ack on air
  assign ack_busy = (state == ACK_WAIT) || (state == ACK_SEND);

  // builder latches the ack fields on the same strobe
  assign ack_launch = start_tx_ack;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state               <= IDLE;
      timer               <= '0;
      num_retrans         <= '0;
      start_tx_ack        <= 1'b0;
      start_retrans       <= 1'b0;
      retrans_in_progress <= 1'b0;
      tx_try_complete     <= 1'b0;
      tx_status           <= '0;
    end else begin
      // strobes are single cycle
      start_tx_ack    <= 1'b0;
      start_retrans   <= 1'b0;
      tx_try_complete <= 1'b0;

      case (state)
        IDLE: begin
          // a received frame wins over our own tx done
          if (ack_owed) begin
            // cycle of ack_owed already counts as the first one
            timer <= `TIMER_W'(1);
            if (wait_cycles == '0) begin
              state        <= ACK_SEND;
              start_tx_ack <= 1'b1;
            end else begin
              state <= ACK_WAIT;
            end
          end else if (phy_tx_done) begin
            timer <= '0;
            if (tx_need_ack) begin
              state               <= WAIT_ACK;
              retrans_in_progress <= 1'b1;
            end else begin
              // nothing to wait for, report done
              tx_try_complete     <= 1'b1;
              tx_status.fail      <= 1'b0;
              tx_status.retry     <= num_retrans;
              num_retrans         <= '0;
              retrans_in_progress <= 1'b0;
            end
          end
        end

        ACK_WAIT: begin
          // sifs wait, then hand the ack to the phy
          if (timer >= wait_cycles) begin
            state        <= ACK_SEND;
            start_tx_ack <= 1'b1;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        ACK_SEND: begin
          // ack on air, phy done closes it
          if (phy_tx_done) begin
            state <= IDLE;
          end
        end

        WAIT_ACK: begin
          timer <= timer + 1'b1;
          if (ack_seen && (timer < timeout_cycles)) begin
            // peer ack in time
            state               <= IDLE;
            tx_try_complete     <= 1'b1;
            tx_status.fail      <= 1'b0;
            tx_status.retry     <= num_retrans;
            num_retrans         <= '0;
            retrans_in_progress <= 1'b0;
          end else if (timer >= timeout_cycles) begin
            state <= IDLE;
            if (retry_left) begin
              // ask for another try right away
              num_retrans   <= num_retrans + 1'b1;
              start_retrans <= 1'b1;
            end else begin
              // out of retries
              tx_try_complete     <= 1'b1;
              tx_status.fail      <= 1'b1;
              tx_status.retry     <= num_retrans;
              num_retrans         <= '0;
              retrans_in_progress <= 1'b0;
            end
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  // ack start is a strobe, never two cycles
  a_start_ack_pulse: assert property (@(posedge clk) disable iff (!rstn)
    start_tx_ack |=> !start_tx_ack);

  // an attempt either retries or completes
  a_done_xor_retry: assert property (@(posedge clk) disable iff (!rstn)
    !(tx_try_complete && start_retrans));

  // retry count bounded by the limit
  a_retry_bound: assert property (@(posedge clk) disable iff (!rstn)
    num_retrans <= retrans_limit);

endmodule

/* rtl/ack_frame_build.sv */
// ack frame field builder
`timescale 1ns/100ps
`include "tx_ack_defines.svh"

module ack_frame_build import tx_ack_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   ack_launch,
  // fields of the frame being acked
  input  frame_kind_t            kind,
  input  logic                   rx_more_frag,
  input  logic [15:0]            rx_duration,
  input  logic [`MAC_ADDR_W-1:0] rx_addr2,
  input  logic [6:0]             sifs_time,
  // ack ppdu fields
  output logic [23:0]            ack_signal,
  output logic [15:0]            ack_fc,
  output logic [15:0]            ack_duration,
  output logic [`MAC_ADDR_W-1:0] ack_ra
);

  logic [16:0] sig_low;
  logic        sig_parity;
  logic        last_frag;
  logic [15:0] dur_left;

  // rate, reserved bit, length
  assign sig_low    = {`ACK_LEN, 1'b0, `ACK_RATE_CODE};
  // even parity over bits 16:0
  assign sig_parity = ^sig_low;

  // data or mgmt with no more fragments gets duration 0
  assign last_frag = ((kind == KIND_DATA) || (kind == KIND_MGMT)) && !rx_more_frag;

  // remaining nav after our ack and its sifs, wraps mod 2^16
  assign dur_left = rx_duration - `ACK_AIR_TIME_US - {9'd0, sifs_time};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ack_signal   <= '0;
      ack_fc       <= '0;
      ack_duration <= '0;
      ack_ra       <= '0;
    end else if (ack_launch) begin
      ack_signal   <= {6'd0, sig_parity, sig_low};
      // flags, subtype, type, protocol version 0
      ack_fc       <= {8'h00, `FC_SUB_ACK, `FC_TYPE_CTRL, 2'b00};
      ack_duration <= last_frag ? 16'd0 : dur_left;
      // ra copied from addr2 of the acked frame
      ack_ra       <= rx_addr2;
    end
  end

endmodule

/* rtl/tx_ack_top.sv */
// tx ack controller top
`timescale 1ns/100ps
`include "tx_ack_defines.svh"

module tx_ack_top import tx_ack_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  // receive side
  input  logic                   rx_valid,
  input  logic                   fcs_ok,
  input  logic [1:0]             fc_type,
  input  logic [3:0]             fc_subtype,
  input  logic                   more_frag,
  input  logic [15:0]            duration,
  input  logic [`MAC_ADDR_W-1:0] addr1,
  input  logic [`MAC_ADDR_W-1:0] addr2,
  input  logic [`MAC_ADDR_W-1:0] self_mac_addr,
  // transmit side
  input  logic                   phy_tx_done,
  input  logic                   tx_need_ack,
  // configuration
  input  logic [7:0]             send_ack_wait_us,
  input  logic [11:0]            ack_timeout_us,
  input  logic [`RETRY_W-1:0]    retrans_limit,
  input  logic [6:0]             sifs_time,
  // controller outputs
  output logic                   start_tx_ack,
  output logic                   ack_busy,
  output logic                   start_retrans,
  output logic                   retrans_in_progress,
  output logic                   tx_try_complete,
  output tx_status_t             tx_status,
  // ack fields
  output logic [23:0]            ack_signal,
  output logic [15:0]            ack_fc,
  output logic [15:0]            ack_duration,
  output logic [`MAC_ADDR_W-1:0] ack_ra
);

  logic                   ack_owed;
  logic                   ack_seen;
  logic                   ack_launch;
  frame_kind_t            kind;
  logic                   rx_more_frag;
  logic [15:0]            rx_duration;
  logic [`MAC_ADDR_W-1:0] rx_addr2;

  // decode
  frame_classify u_classify (
    .clk           (clk),
    .rstn          (rstn),
    .rx_valid      (rx_valid),
    .fcs_ok        (fcs_ok),
    .fc_type       (fc_type),
    .fc_subtype    (fc_subtype),
    .more_frag     (more_frag),
    .duration      (duration),
    .addr1         (addr1),
    .addr2         (addr2),
    .self_mac_addr (self_mac_addr),
    .ack_owed      (ack_owed),
    .ack_seen      (ack_seen),
    .kind          (kind),
    .rx_more_frag  (rx_more_frag),
    .rx_duration   (rx_duration),
    .rx_addr2      (rx_addr2)
  );

  // execute
  tx_ack_fsm u_fsm (
    .clk                 (clk),
    .rstn                (rstn),
    .ack_owed            (ack_owed),
    .ack_seen            (ack_seen),
    .phy_tx_done         (phy_tx_done),
    .tx_need_ack         (tx_need_ack),
    .send_ack_wait_us    (send_ack_wait_us),
    .ack_timeout_us      (ack_timeout_us),
    .retrans_limit       (retrans_limit),
    .start_tx_ack        (start_tx_ack),
    .ack_launch          (ack_launch),
    .ack_busy            (ack_busy),
    .start_retrans       (start_retrans),
    .retrans_in_progress (retrans_in_progress),
    .tx_try_complete     (tx_try_complete),
    .tx_status           (tx_status)
  );

  // result
  ack_frame_build u_build (
    .clk          (clk),
    .rstn         (rstn),
    .ack_launch   (ack_launch),
    .kind         (kind),
    .rx_more_frag (rx_more_frag),
    .rx_duration  (rx_duration),
    .rx_addr2     (rx_addr2),
    .sifs_time    (sifs_time),
    .ack_signal   (ack_signal),
    .ack_fc       (ack_fc),
    .ack_duration (ack_duration),
    .ack_ra       (ack_ra)
  );

endmodule

/* verif/tx_ack_checker.sv */
// tx ack output checker
`timescale 1ns/100ps
`include "tx_ack_defines.svh"

module tx_ack_checker import tx_ack_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  // dut inputs that set the expected timing
  input  logic                   rx_valid,
  input  logic [7:0]             send_ack_wait_us,
  // dut outputs
  input  logic                   start_tx_ack,
  input  logic                   ack_busy,
  input  logic                   start_retrans,
  input  logic                   retrans_in_progress,
  input  logic                   tx_try_complete,
  input  tx_status_t             tx_status,
  input  logic [23:0]            ack_signal,
  input  logic [15:0]            ack_fc,
  input  logic [15:0]            ack_duration,
  input  logic [`MAC_ADDR_W-1:0] ack_ra,
  // expectations from the testbench
  input  logic                   ack_expected,
  input  logic [103:0]           exp_ack,
  input  logic                   exp_fail,
  input  logic [`RETRY_W-1:0]    exp_retry,
  input  logic                   test_done,
  input  int                     test_id,
  input  logic                   run_done,
  output int                     err_count
);

  logic [23:0]            e_sig;
  logic [15:0]            e_fc;
  logic [15:0]            e_dur;
  logic [`MAC_ADDR_W-1:0] e_ra;
  int   since_rx     = 0;
  int   due          = 0;
  int   checks       = 0;
  int   test_errs    = 0;
  int   total_checks = 0;
  int   err_total    = 0;
  int   retrans_seen = 0;
  logic fields_due   = 1'b0;

  assign {e_sig, e_fc, e_dur, e_ra} = exp_ack;
  assign err_count = err_total;

  task automatic report_mismatch(input string msg);
    $display("error at %0t: %s", $time, msg);
    err_total++;
    test_errs++;
  endtask

  // everything sampled mid cycle, away from the rising edge
  always @(negedge clk) begin
    // classify stage plus the sifs wait plus the launch cycle
    due = send_ack_wait_us * `CLK_PER_US + 2;
    if (!rstn) begin
      since_rx     = 0;
      fields_due   = 1'b0;
      retrans_seen = 0;
    end else begin
      since_rx = rx_valid ? 1 : since_rx + 1;
      // ack fields settle one cycle after the launch
      if (fields_due) begin
        fields_due = 1'b0;
        checks++;
        if (!ack_busy)
          report_mismatch("ack_busy low while the ack is on air");
        if (ack_signal !== e_sig)
          report_mismatch($sformatf("ack signal got %h expected %h", ack_signal, e_sig));
        if (ack_fc !== e_fc)
          report_mismatch($sformatf("ack fc got %h expected %h", ack_fc, e_fc));
        if (ack_duration !== e_dur)
          report_mismatch($sformatf("ack duration got %h expected %h", ack_duration, e_dur));
        if (ack_ra !== e_ra)
          report_mismatch($sformatf("ack ra got %h expected %h", ack_ra, e_ra));
      end
      if (start_tx_ack) begin
        checks++;
        if (!ack_expected) begin
          report_mismatch("ack started although no ack was owed");
        end else if (since_rx != due) begin
          report_mismatch($sformatf("ack start after %0d cycles expected %0d", since_rx, due));
        end
        fields_due = 1'b1;
      end
      // every retry must come with the in progress flag
      if (start_retrans) begin
        checks++;
        retrans_seen++;
        if (!retrans_in_progress)
          report_mismatch("start_retrans with retrans_in_progress low");
      end
      if (tx_try_complete) begin
        checks++;
        if (tx_status.fail !== exp_fail)
          report_mismatch($sformatf("status fail got %b expected %b", tx_status.fail, exp_fail));
        if (tx_status.retry !== exp_retry)
          report_mismatch($sformatf("status retry got %0d expected %0d",
                                    tx_status.retry, exp_retry));
        if (retrans_seen != exp_retry)
          report_mismatch($sformatf("saw %0d retrans pulses expected %0d",
                                    retrans_seen, exp_retry));
        retrans_seen = 0;
      end
      if (test_done) begin
        $display("test %0d finished: %0d checks, %0d errors", test_id, checks, test_errs);
        total_checks += checks;
        checks    = 0;
        test_errs = 0;
      end
    end
  end

  always @(posedge run_done) begin
    $display("totals: %0d checks, %0d errors", total_checks, err_total);
  end

endmodule

/* verif/tb_tx_ack.sv */
// tx ack controller testbench
`timescale 1ns/100ps
`include "tx_ack_defines.svh"

module tb_tx_ack import tx_ack_pkg::*; ();

  localparam int N_FRAMES   = 20;
  localparam int NUM_TESTS  = 5;
  localparam int WAIT_US    = 1;
  localparam int TIMEOUT_US = 2;
  localparam int LIMIT      = 2;
  localparam int WAIT_CYC   = WAIT_US * `CLK_PER_US + 2;
  localparam int TO_CYC     = TIMEOUT_US * `CLK_PER_US;
  // every test bounded by a full retry sequence per frame with wide margin
  localparam int MAX_CYCLES = NUM_TESTS * N_FRAMES * TO_CYC * (LIMIT + 1);
  localparam logic [47:0] SELF_MAC = 48'h021a_3c55_7e91;

  logic clk;
  logic rstn;
  logic rx_valid, fcs_ok, more_frag, phy_tx_done, tx_need_ack;
  logic [1:0]   fc_type;
  logic [3:0]   fc_subtype;
  logic [15:0]  duration;
  logic [47:0]  addr1, addr2, self_mac_addr;
  logic [7:0]   send_ack_wait_us;
  logic [11:0]  ack_timeout_us;
  logic [3:0]   retrans_limit;
  logic [6:0]   sifs_time;
  logic start_tx_ack, ack_busy, start_retrans, retrans_in_progress, tx_try_complete;
  tx_status_t   tx_status;
  logic [23:0]  ack_signal;
  logic [15:0]  ack_fc, ack_duration;
  logic [47:0]  ack_ra;
  // expectations handed to the checker
  logic         ack_expected, exp_fail, test_done, run_done;
  logic [103:0] exp_ack;
  logic [3:0]   exp_retry;
  int           test_id, err_count, kind_sel, i;
  int           cycles = 0;
  logic [31:0]  rng = 32'h4130_a4a9;
  logic [31:0]  r, r2, r3;
  logic [47:0]  a2;

  tx_ack_top dut (.*);

  tx_ack_checker u_check (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles, a DUT event never came", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // ack fields as {signal, fc, duration, ra}
  function automatic logic [103:0] expected_ack(input int k, input logic mf,
      input logic [15:0] dur, input logic [47:0] ra, input logic [6:0] sifs);
    logic [23:0] sig;
    logic [15:0] d;
    int          ones;
    int          b;
    sig       = 24'd0;
    sig[3:0]  = 4'b1011;
    sig[16:5] = 12'd14;
    ones      = 0;
    for (b = 0; b < 17; b++) ones += sig[b];
    // even parity
    sig[17] = ones[0];
    // data (0) and mgmt (1) on the last fragment end the nav
    if ((k < 2) && !mf) d = 16'd0;
    else d = dur - 16'd44 - {9'd0, sifs};
    // fc 0x00d4 is control type with ack subtype
    return {sig, 16'h00d4, d, ra};
  endfunction

  task automatic send_frame(input logic [1:0] t, input logic [3:0] s, input logic mf,
      input logic [15:0] d, input logic [47:0] a1, input logic [47:0] a, input logic fcs);
    @(negedge clk);
    fc_type    <= t;
    fc_subtype <= s;
    more_frag  <= mf;
    duration   <= d;
    addr1      <= a1;
    addr2      <= a;
    fcs_ok     <= fcs;
    rx_valid   <= 1'b1;
    @(negedge clk);
    rx_valid   <= 1'b0;
  endtask

  task automatic pulse_tx_done(input logic need_ack);
    @(negedge clk);
    phy_tx_done <= 1'b1;
    tx_need_ack <= need_ack;
    @(negedge clk);
    phy_tx_done <= 1'b0;
  endtask

  // which picks ack start (0) or retransmit (1) or attempt complete (2)
  // looks from the current falling edge on
  task automatic wait_event(input int which);
    while (!((which == 0) ? start_tx_ack : (which == 1) ? start_retrans : tx_try_complete))
      @(negedge clk);
  endtask

  task automatic finish_test(input int id);
    @(negedge clk);
    test_id   <= id;
    test_done <= 1'b1;
    @(negedge clk);
    test_done <= 1'b0;
  endtask

  initial begin
    rstn             = 1'b0;
    rx_valid         = 1'b0;
    fcs_ok           = 1'b0;
    more_frag        = 1'b0;
    phy_tx_done      = 1'b0;
    tx_need_ack      = 1'b0;
    fc_type          = 2'b00;
    fc_subtype       = 4'd0;
    duration         = 16'd0;
    addr1            = '0;
    addr2            = '0;
    self_mac_addr    = SELF_MAC;
    send_ack_wait_us = 8'(WAIT_US);
    ack_timeout_us   = 12'(TIMEOUT_US);
    retrans_limit    = 4'(LIMIT);
    sifs_time        = 7'd16;
    ack_expected     = 1'b0;
    exp_ack          = '0;
    exp_fail         = 1'b0;
    exp_retry        = '0;
    test_done        = 1'b0;
    run_done         = 1'b0;
    test_id          = 0;
    repeat (5) @(negedge clk);
    rstn <= 1'b1;

    // acked frames of every kind
    ack_expected <= 1'b1;
    for (i = 0; i < N_FRAMES; i++) begin
      r  = next_rand();
      r2 = next_rand();
      r3 = next_rand();
      a2 = {r2[15:0], r3};
      kind_sel = int'(r % 32'd5);
      sifs_time <= r[14:8];
      exp_ack   <= expected_ack(kind_sel, r[7], r[31:16], a2, r[14:8]);
      case (kind_sel)
        0: send_frame(`FC_TYPE_DATA, r[3:0], r[7], r[31:16], SELF_MAC, a2, 1'b1);
        1: send_frame(`FC_TYPE_MGMT, (r[3:0] == `FC_SUB_ACTION_NOACK) ? 4'd0 : r[3:0],
                      r[7], r[31:16], SELF_MAC, a2, 1'b1);
        2: send_frame(`FC_TYPE_CTRL, `FC_SUB_BAR, r[7], r[31:16], SELF_MAC, a2, 1'b1);
        3: send_frame(`FC_TYPE_CTRL, `FC_SUB_BA, r[7], r[31:16], SELF_MAC, a2, 1'b1);
        default: send_frame(`FC_TYPE_CTRL, `FC_SUB_PSPOLL, r[7], r[31:16], SELF_MAC, a2, 1'b1);
      endcase
      wait_event(0);
      // ends ack_send
      pulse_tx_done(1'b0);
    end
    finish_test(1);

    // bad fcs then foreign addr1 then action no ack
    ack_expected <= 1'b0;
    r = next_rand();
    send_frame(`FC_TYPE_DATA, 4'd0, 1'b0, r[15:0], SELF_MAC, {16'h0, r}, 1'b0);
    repeat (WAIT_CYC + 20) @(negedge clk);
    send_frame(`FC_TYPE_DATA, 4'd0, 1'b0, r[15:0], SELF_MAC ^ {16'h8000, r}, SELF_MAC, 1'b1);
    repeat (WAIT_CYC + 20) @(negedge clk);
    send_frame(`FC_TYPE_MGMT, `FC_SUB_ACTION_NOACK, 1'b0, r[15:0], SELF_MAC, {16'h0, r}, 1'b1);
    repeat (WAIT_CYC + 20) @(negedge clk);
    finish_test(2);

    // own frame without ack
    exp_fail  <= 1'b0;
    exp_retry <= 4'd0;
    pulse_tx_done(1'b0);
    wait_event(2);
    finish_test(3);

    // one timeout then the peer ack halfway through
    exp_retry <= 4'd1;
    pulse_tx_done(1'b1);
    wait_event(1);
    pulse_tx_done(1'b1);
    repeat (TO_CYC / 2) @(negedge clk);
    send_frame(`FC_TYPE_CTRL, `FC_SUB_ACK, 1'b0, 16'd0, SELF_MAC, '0, 1'b1);
    wait_event(2);
    finish_test(4);

    // no ack ever so the retries run out
    exp_fail  <= 1'b1;
    exp_retry <= 4'(LIMIT);
    pulse_tx_done(1'b1);
    repeat (LIMIT) begin
      wait_event(1);
      pulse_tx_done(1'b1);
    end
    wait_event(2);
    finish_test(5);

    run_done <= 1'b1;
    repeat (2) @(negedge clk);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
rtl/tx_ack_pkg.sv
rtl/frame_classify.sv
rtl/tx_ack_fsm.sv
rtl/ack_frame_build.sv
rtl/tx_ack_top.sv
verif/tx_ack_checker.sv
verif/tb_tx_ack.sv
